//--- all.f
+incdir+common
common/miner_link_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/header_collector.sv
verilog/nonce_sender.sv
verilog/uart_core.sv
verification/uart_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = uart_core_tb
FILELIST  = all.f
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- verification/uart_core_tb.sv
`include "miner_link_defs.svh"

module uart_core_tb
    import miner_link_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS = `CLKS_PER_BIT;
    localparam int HDR_W = `HEADER_BYTES * 8;
    localparam int NONCE_W = `NONCE_BYTES * 8;
    localparam int FRAME_CLKS = 10 * CLKS;

    logic        clock;
    logic        rst;
    logic        rxd;
    logic        txd;
    nonce_t      nonce_input;
    logic        transmit_data;
    header_t     header_data;
    logic        header_valid;
    logic        frame_error;
    logic [31:0] byte_count;
    logic        busy;

    integer      seed;
    int          valid_seen = 0;
    int          error_seen = 0;
    header_t     last_header;
    // good frames put on rxd since reset
    logic [31:0] good_bytes_sent;

    uart_core uart_core_inst (
        .clock         (clock),
        .rst           (rst),
        .rxd           (rxd),
        .txd           (txd),
        .nonce_input   (nonce_input),
        .transmit_data (transmit_data),
        .header_data   (header_data),
        .header_valid  (header_valid),
        .frame_error   (frame_error),
        .byte_count    (byte_count),
        .busy          (busy)
    );

    always #4 clock = ~clock;

    // pulse counters, read before the DUT moves on
    always @(posedge clock) begin
        if (!rst && header_valid) begin
            valid_seen  = valid_seen + 1;
            last_header = header_data;
        end
        if (!rst && frame_error) begin
            error_seen = error_seen + 1;
        end
    end

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [HDR_W-1:0] expected, logic [HDR_W-1:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(string what);
        $display("timed out waiting for %s", what);
        stop_with_failure();
    endtask

    // all drivers start and end 1 ns after a rising edge
    task automatic idle_clocks(int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic drive_bit(logic value);
        rxd = value;
        idle_clocks(CLKS);
    endtask

    task automatic send_byte(byte_t value, bit bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]);
        end
        drive_bit(!bad_stop);
        rxd = 1'b1;
        if (!bad_stop) begin
            good_bytes_sent = good_bytes_sent + 1;
        end
    endtask

    // byte i of a header lands i bytes below the top
    task automatic send_random_bytes(int count, output header_t expected);
        byte_t value;
        expected = '0;
        for (int i = 0; i < count; i++) begin
            value = byte_t'($random(seed));
            expected[HDR_W-1-8*i -: 8] = value;
            send_byte(value, 1'b0);
        end
    endtask

    task automatic recv_byte(output byte_t value);
        int n;
        n = 0;
        @(negedge clock);
        while (txd !== 1'b0) begin
            @(negedge clock);
            n++;
            if (n > 4 * FRAME_CLKS) report_timeout("a start bit on txd");
        end
        // move to mid start bit, then one bit time per sample
        repeat (CLKS / 2) @(negedge clock);
        if (txd !== 1'b0) begin
            $display("start bit on txd did not last half a bit");
            stop_with_failure();
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clock);
            value[i] = txd;
        end
        repeat (CLKS) @(negedge clock);
        if (txd !== 1'b1) begin
            $display("stop bit on txd was low");
            stop_with_failure();
        end
        idle_clocks(1);
    endtask

    task automatic wait_header(int target);
        int n;
        n = 0;
        while (valid_seen < target) begin
            @(negedge clock);
            n++;
            if (n > 4 * FRAME_CLKS) report_timeout("header_valid");
        end
        idle_clocks(1);
    endtask

    task automatic wait_frame_error(int target);
        int n;
        n = 0;
        while (error_seen < target) begin
            @(negedge clock);
            n++;
            if (n > 4 * FRAME_CLKS) report_timeout("frame_error");
        end
        idle_clocks(1);
    endtask

    task automatic test_reset_state();
        check("reset txd", 1'b1, txd);
        check("reset busy", 1'b0, busy);
        check("reset header_valid", 1'b0, header_valid);
        check("reset frame_error", 1'b0, frame_error);
        check("reset byte_count", 32'd0, byte_count);
    endtask

    task automatic receive_header(string name);
        header_t expected;
        int      valid_before;
        valid_before = valid_seen;
        send_random_bytes(`HEADER_BYTES, expected);
        wait_header(valid_before + 1);
        check({name, " data"}, expected, last_header);
        check({name, " data held"}, expected, header_data);
        check({name, " pulses"}, valid_before + 1, valid_seen);
        check({name, " count"}, good_bytes_sent, byte_count);
    endtask

    task automatic test_frame_error();
        int error_before;
        error_before = error_seen;
        send_byte(8'h5a, 1'b1);
        wait_frame_error(error_before + 1);
        idle_clocks(2 * CLKS);
        check("frame_error pulses", error_before + 1, error_seen);
        check("frame_error count", good_bytes_sent, byte_count);
        receive_header("frame_error recovery");
    endtask

    task automatic test_idle_discard();
        header_t partial;
        send_random_bytes(10, partial);
        idle_clocks(`HEADER_IDLE_CLKS + 2 * CLKS);
        receive_header("idle_discard");
    endtask

    // request edge while busy comes in after the first byte
    task automatic receive_nonce(string name, bit toggle_request);
        nonce_t value;
        byte_t  got;
        value = nonce_t'($random(seed));
        nonce_input = value;
        transmit_data = 1'b1;
        idle_clocks(1);
        nonce_input = ~value;
        for (int i = 0; i < `NONCE_BYTES; i++) begin
            recv_byte(got);
            check($sformatf("%s byte %0d", name, i), value[NONCE_W-1-8*i -: 8], got);
            if (toggle_request && i == 0) begin
                transmit_data = 1'b0;
                idle_clocks(1);
                transmit_data = 1'b1;
            end
        end
        // busy holds through the last stop bit and drops one bit time later
        check({name, " busy in stop bit"}, 1'b1, busy);
        idle_clocks(CLKS);
        check({name, " busy"}, 1'b0, busy);
        check({name, " txd idle"}, 1'b1, txd);
    endtask

    task automatic test_request_hold();
        transmit_data = 1'b0;
        idle_clocks(4);
        receive_nonce("request_hold", 1'b1);
        for (int n = 0; n < 3 * FRAME_CLKS; n++) begin
            @(negedge clock);
            if (txd !== 1'b1 || busy !== 1'b0) begin
                $display("a second reply started after a request edge while busy");
                stop_with_failure();
            end
        end
        transmit_data = 1'b0;
        idle_clocks(1);
    endtask

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        rxd = 1'b1;
        nonce_input = '0;
        transmit_data = 1'b0;
        seed = 32'h695f;
        good_bytes_sent = '0;
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;
        test_reset_state();
        receive_header("header_rx");
        test_frame_error();
        test_idle_discard();
        receive_nonce("nonce_tx", 1'b0);
        test_request_hold();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog/uart_core.sv
module uart_core
    import miner_link_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        rxd,
    output logic        txd,
    input  nonce_t      nonce_input,
    input  logic        transmit_data,
    output header_t     header_data,
    output logic        header_valid,
    output logic        frame_error,
    output logic [31:0] byte_count,
    output logic        busy
);

    // receive side
    byte_t rx_byte;
    logic  rx_strobe;

    // transmit side
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_busy;

    uart_rx uart_rx_inst (
        .clock       (clock),
        .rst         (rst),
        .rxd         (rxd),
        .rx_byte     (rx_byte),
        .rx_strobe   (rx_strobe),
        .frame_error (frame_error)
    );

    header_collector header_collector_inst (
        .clock        (clock),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .header       (header_data),
        .header_valid (header_valid),
        .byte_count   (byte_count)
    );

    nonce_sender nonce_sender_inst (
        .clock         (clock),
        .rst           (rst),
        .transmit_data (transmit_data),
        .nonce_input   (nonce_input),
        .tx_busy       (tx_busy),
        .tx_byte       (tx_byte),
        .tx_start      (tx_start),
        .busy          (busy)
    );

    uart_tx uart_tx_inst (
        .clock    (clock),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

//--- verilog/nonce_sender.sv
`include "miner_link_defs.svh"

module nonce_sender
    import miner_link_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   transmit_data,
    input  nonce_t nonce_input,
    input  logic   tx_busy,
    output byte_t  tx_byte,
    output logic   tx_start,
    output logic   busy
);

    localparam int NONCE_W = `NONCE_BYTES * 8;
    localparam int LEFT_W = $clog2(`NONCE_BYTES + 1);

    typedef enum logic [1:0] {
        NS_IDLE,
        NS_ARM,
        NS_WAIT
    } ns_state_t;

    ns_state_t         state;
    logic              req_prev;
    logic              req_rise;
    nonce_t            nonce_sr;
    logic [LEFT_W-1:0] bytes_left;

    assign req_rise = transmit_data && !req_prev;

    always_ff @(posedge clock) begin
        if (rst) begin
            req_prev <= 1'b0;
        end else begin
            req_prev <= transmit_data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= NS_IDLE;
            tx_start   <= 1'b0;
            busy       <= 1'b0;
            bytes_left <= '0;
        end else begin
            case (state)
                NS_IDLE: begin
                    // edges while a reply is going out never reach here
                    if (req_rise) begin
                        nonce_sr   <= nonce_input;
                        tx_start   <= 1'b1;
                        busy       <= 1'b1;
                        bytes_left <= LEFT_W'(`NONCE_BYTES - 1);
                        state      <= NS_ARM;
                    end
                end
                NS_ARM: begin
                    // transmitter latches the top byte on this edge
                    tx_start <= 1'b0;
                    nonce_sr <= {nonce_sr[NONCE_W-9:0], 8'h00};
                    state    <= NS_WAIT;
                end
                NS_WAIT: begin
                    if (!tx_busy) begin
                        if (bytes_left == '0) begin
                            busy  <= 1'b0;
                            state <= NS_IDLE;
                        end else begin
                            tx_start   <= 1'b1;
                            bytes_left <= bytes_left - 1'b1;
                            state      <= NS_ARM;
                        end
                    end
                end
                default: state <= NS_IDLE;
            endcase
        end
    end

    // msb first
    assign tx_byte = nonce_sr[NONCE_W-1 -: 8];

    a_start_only_when_busy: assert property (@(posedge clock) disable iff (rst)
        tx_start |-> busy);

endmodule

//--- verilog/header_collector.sv
`include "miner_link_defs.svh"

module header_collector
    import miner_link_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  byte_t       rx_byte,
    input  logic        rx_strobe,
    output header_t     header,
    output logic        header_valid,
    output logic [31:0] byte_count
);

    localparam int HDR_W = `HEADER_BYTES * 8;
    localparam int POS_W = $clog2(`HEADER_BYTES + 1);
    localparam int IDLE_CLKS = `HEADER_IDLE_CLKS;
    localparam int IDLE_W = $clog2(IDLE_CLKS + 1);

    header_t           asm_reg;
    logic [POS_W-1:0]  pos;
    logic [POS_W-1:0]  base_pos;
    logic [IDLE_W-1:0] idle_cnt;
    logic              idle_timeout;

    // a frame left hanging too long is dropped
    assign idle_timeout = (pos != '0) && (idle_cnt == IDLE_W'(IDLE_CLKS - 1));
    // byte on the timeout clock starts a fresh header
    assign base_pos = idle_timeout ? '0 : pos;

    always_ff @(posedge clock) begin
        if (rst) begin
            pos          <= '0;
            idle_cnt     <= '0;
            header_valid <= 1'b0;
            byte_count   <= '0;
        end else begin
            header_valid <= 1'b0;
            if (rx_strobe) begin
                idle_cnt   <= '0;
                byte_count <= byte_count + 1'b1;
                if (base_pos == POS_W'(`HEADER_BYTES - 1)) begin
                    pos          <= '0;
                    header_valid <= 1'b1;
                end else begin
                    pos <= base_pos + 1'b1;
                end
            end else if (idle_timeout) begin
                pos      <= '0;
                idle_cnt <= '0;
            end else if (pos != '0) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // payload path, earlier bytes move up
    always_ff @(posedge clock) begin
        if (rx_strobe) begin
            asm_reg <= {asm_reg[HDR_W-9:0], rx_byte};
            if (base_pos == POS_W'(`HEADER_BYTES - 1)) begin
                header <= {asm_reg[HDR_W-9:0], rx_byte};
            end
        end
    end

    a_pos_in_range: assert property (@(posedge clock) disable iff (rst)
        pos <= POS_W'(`HEADER_BYTES));

endmodule

//--- uart/uart_tx.sv
`include "miner_link_defs.svh"

module uart_tx
    import miner_link_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  txd,
    output logic  tx_busy
);

    localparam int CLKS = `CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic [9:0]       frame_sr;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;

    always_ff @(posedge clock) begin
        if (rst) begin
            frame_sr <= '1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                // stop, data, start from msb down
                frame_sr <= {1'b1, tx_byte, 1'b0};
                tx_busy  <= 1'b1;
            end
        end else if (clk_cnt == CNT_W'(CLKS - 1)) begin
            clk_cnt <= '0;
            // ones shift in so the line idles high once done
            frame_sr <= {1'b1, frame_sr[9:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign txd = frame_sr[0];

    // the sender must wait for the previous frame to finish
    a_no_start_when_busy: assert property (@(posedge clock) disable iff (rst)
        tx_start |-> !tx_busy);

endmodule

//--- uart/uart_rx.sv
`include "miner_link_defs.svh"

module uart_rx
    import miner_link_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  rxd,
    output byte_t rx_byte,
    output logic  rx_strobe,
    output logic  frame_error
);

    localparam int CLKS = `CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       rxd_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    byte_t            data_sr;

    // line idles high
    always_ff @(posedge clock) begin
        if (rst) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            rx_strobe   <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_strobe   <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rxd_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // line back high before mid start bit means a glitch
                    if (rxd_sync[1]) begin
                        state <= RX_IDLE;
                    end else if (clk_cnt == CNT_W'(CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CNT_W'(CLKS - 1)) begin
                        clk_cnt <= '0;
                        // lsb arrives first
                        data_sr <= {rxd_sync[1], data_sr[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CNT_W'(CLKS - 1)) begin
                        clk_cnt     <= '0;
                        rx_strobe   <= rxd_sync[1];
                        frame_error <= !rxd_sync[1];
                        state       <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // shift register is stable through the stop bit
    assign rx_byte = data_sr;

    a_strobe_or_error: assert property (@(posedge clock) disable iff (rst)
        !(rx_strobe && frame_error));

endmodule

//--- common/miner_link_pkg.sv
`include "miner_link_defs.svh"

package miner_link_pkg;

    // one byte on the serial line
    typedef logic [7:0] byte_t;

    // full block header, first received byte in the top byte
    typedef logic [`HEADER_BYTES*8-1:0] header_t;

    // nonce from the hashing side
    typedef logic [`NONCE_BYTES*8-1:0] nonce_t;

endpackage

//--- common/miner_link_defs.svh
`ifndef MINER_LINK_DEFS_SVH
`define MINER_LINK_DEFS_SVH

// serial bit timing, in clock cycles per bit
`define CLKS_PER_BIT 16

// bytes in one block header from the host
`define HEADER_BYTES 80

// bytes in one nonce reply, sent msb first
`define NONCE_BYTES 4

// partial header dropped after this many quiet clocks
`define HEADER_IDLE_CLKS (40 * `CLKS_PER_BIT)

`endif
